// File: Makefile
# Verilator build and run of the decode stage testbench

sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_id_stage -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: source/branch_unit.sv
// branch_unit resolves conditional branches and jumps and computes the redirect target for fetch
`timescale 1ns/1ns
`default_nettype none

module branch_unit #(
  parameter int XLEN = 64
) (
  input  wire                          i_issue,
  input  wire [XLEN-1:0]               i_pc,
  input  wire [XLEN-1:0]               i_rs1_data,
  input  wire [XLEN-1:0]               i_rs2_data,
  input  wire [XLEN-1:0]               i_imm,
  input  wire                          i_br_en,
  input  wire                          i_jump,
  input  wire                          i_jalr,
  input  wire [id_pkg::BR_FUNC_WD-1:0] i_br_func,
  output logic                         o_br_taken,
  output logic [XLEN-1:0]              o_br_target
);

  logic            eq;
  logic            lt;
  logic            ltu;
  logic            cond;
  logic [XLEN-1:0] sum;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      3'b000:  cond = eq;    // beq
      3'b001:  cond = !eq;   // bne
      3'b100:  cond = lt;    // blt
      3'b101:  cond = !lt;   // bge
      3'b110:  cond = ltu;
      3'b111:  cond = !ltu;
      default: cond = 1'b0;  // 010/011 not branches
    endcase

    o_br_taken = i_issue && (i_jump || (i_br_en && cond));

    // the decoder marks a branch or a jump and never both
    if (i_br_en) begin
      a_branch_not_jump : assert (!i_jump)
        else $error("branch and jump raised together");
    end
  end

  // jalr target is register relative with the lsb dropped
  assign sum         = (i_jalr ? i_rs1_data : i_pc) + i_imm;
  assign o_br_target = i_jalr ? {sum[XLEN-1:1], 1'b0} : sum;

endmodule

`default_nettype wire

// File: source/gpr_file.sv
// gpr_file is a 32-entry integer register file with two combinational reads and one write
`timescale 1ns/1ns
`default_nettype none

module gpr_file #(
  parameter int XLEN = 64
) (
  input  wire                           i_clk,
  input  wire [id_pkg::GPR_ADDR_WD-1:0] i_raddr1,
  input  wire [id_pkg::GPR_ADDR_WD-1:0] i_raddr2,
  input  wire                           i_wen,
  input  wire [id_pkg::GPR_ADDR_WD-1:0] i_waddr,
  input  wire [XLEN-1:0]                i_wdata,
  output logic [XLEN-1:0]               o_rdata1,
  output logic [XLEN-1:0]               o_rdata2
);
  import id_pkg::*;

  logic [XLEN-1:0] regs [1:2**GPR_ADDR_WD-1];  // x0 is not stored

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // decode stalls on a pending write-back so reads need no bypass
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // a write is visible at the next edge
  a_write_visible : assert property (
    @(posedge i_clk)
    (i_wen && i_waddr != '0) |=> regs[$past(i_waddr)] == $past(i_wdata)
  ) else $error("register write not visible one cycle later");

endmodule

`default_nettype wire

// File: source/id_pkg.sv
// id_pkg: widths, opcode and ALU codes, operand selects and the instruction word
`default_nettype none

package id_pkg;

  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int ALU_OP_WD   = 4;
  localparam int MEM_OP_WD   = 3;   // funct3 of load/store
  localparam int BR_FUNC_WD  = 3;

  // major opcodes
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;

  // execute stage ALU codes
  localparam logic [ALU_OP_WD-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_WD-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_WD-1:0] ALU_SLL  = 4'd2;
  localparam logic [ALU_OP_WD-1:0] ALU_SLT  = 4'd3;
  localparam logic [ALU_OP_WD-1:0] ALU_SLTU = 4'd4;
  localparam logic [ALU_OP_WD-1:0] ALU_XOR  = 4'd5;
  localparam logic [ALU_OP_WD-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_WD-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_WD-1:0] ALU_OR   = 4'd8;
  localparam logic [ALU_OP_WD-1:0] ALU_AND  = 4'd9;
  localparam logic [ALU_OP_WD-1:0] ALU_LUI  = 4'd10;  // pass operand 2

  localparam logic SRC1_RS1 = 1'b0;
  localparam logic SRC1_PC  = 1'b1;

  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2;  // link address pc+4

  // one word, two views
  typedef union packed {
    struct packed {
      logic [6:0]             funct7;
      logic [GPR_ADDR_WD-1:0] rs2;
      logic [GPR_ADDR_WD-1:0] rs1;
      logic [2:0]             funct3;
      logic [GPR_ADDR_WD-1:0] rd;
      logic [6:0]             opcode;
    } r;
    struct packed {
      logic [11:0] imm_hi;  // inst[31:20]
      logic [12:0] imm_lo;  // inst[19:7]
      logic [6:0]  opcode;
    } raw;
  } inst_u;

endpackage

`default_nettype wire

// File: source/id_stage.sv
// id_stage: instruction decode stage, controller plus decoder, register file and branch unit
`timescale 1ns/1ns
`default_nettype none

module id_stage #(
  parameter int XLEN = 64
) (
  input  wire                            i_clk,
  input  wire                            i_rst,
  // from fetch
  input  wire                            i_fs_valid,
  input  wire [id_pkg::INST_WD-1:0]      i_fs_inst,
  input  wire [XLEN-1:0]                 i_fs_pc,
  output logic                           o_ds_allowin,
  // in-flight destinations
  input  wire [id_pkg::GPR_ADDR_WD-1:0]  i_es_gpr_rd,
  input  wire [id_pkg::GPR_ADDR_WD-1:0]  i_ms_gpr_rd,
  input  wire [id_pkg::GPR_ADDR_WD-1:0]  i_ws_gpr_rd,
  // write-back port
  input  wire                            i_ws_gpr_wen,
  input  wire [id_pkg::GPR_ADDR_WD-1:0]  i_ws_gpr_waddr,
  input  wire [XLEN-1:0]                 i_ws_gpr_wdata,
  // to execute
  input  wire                            i_es_allowin,
  output logic                           o_ds_to_es_valid,
  output logic [XLEN-1:0]                o_es_pc,
  output logic [XLEN-1:0]                o_es_rs1_data,
  output logic [XLEN-1:0]                o_es_rs2_data,
  output logic [XLEN-1:0]                o_es_imm,
  output logic [id_pkg::ALU_OP_WD-1:0]   o_es_alu_op,
  output logic                           o_es_src1_sel,
  output logic [1:0]                     o_es_src2_sel,
  output logic                           o_es_word_op,
  output logic [id_pkg::GPR_ADDR_WD-1:0] o_es_rd,
  output logic                           o_es_gpr_wen,
  output logic                           o_es_mem_ren,
  output logic                           o_es_mem_wen,
  output logic [id_pkg::MEM_OP_WD-1:0]   o_es_mem_op,
  output logic                           o_es_invalid,
  // to fetch
  output logic                           o_br_taken,
  output logic [XLEN-1:0]                o_br_target
);
  import id_pkg::*;

  inst_u                 ds_inst;
  logic                  issue;
  logic                  br_en;
  logic                  jump;
  logic                  jalr;
  logic [BR_FUNC_WD-1:0] br_func;

  id_stage_ctrl #(
    .XLEN (XLEN)
  ) ctrl_i (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_valid       (i_fs_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_es_gpr_rd      (i_es_gpr_rd),
    .i_ms_gpr_rd      (i_ms_gpr_rd),
    .i_ws_gpr_rd      (i_ws_gpr_rd),
    .o_inst           (ds_inst),
    .o_pc             (o_es_pc),
    .o_issue          (issue),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid)
  );

  inst_decoder #(
    .XLEN (XLEN)
  ) decoder_i (
    .i_inst     (ds_inst),
    .o_imm      (o_es_imm),
    .o_alu_op   (o_es_alu_op),
    .o_src1_sel (o_es_src1_sel),
    .o_src2_sel (o_es_src2_sel),
    .o_word_op  (o_es_word_op),
    .o_rd       (o_es_rd),
    .o_gpr_wen  (o_es_gpr_wen),
    .o_mem_ren  (o_es_mem_ren),
    .o_mem_wen  (o_es_mem_wen),
    .o_mem_op   (o_es_mem_op),
    .o_br_en    (br_en),
    .o_jump     (jump),
    .o_jalr     (jalr),
    .o_br_func  (br_func),
    .o_invalid  (o_es_invalid)
  );

  gpr_file #(
    .XLEN (XLEN)
  ) gpr_i (
    .i_clk    (i_clk),
    .i_raddr1 (ds_inst.r.rs1),
    .i_raddr2 (ds_inst.r.rs2),
    .i_wen    (i_ws_gpr_wen),
    .i_waddr  (i_ws_gpr_waddr),
    .i_wdata  (i_ws_gpr_wdata),
    .o_rdata1 (o_es_rs1_data),
    .o_rdata2 (o_es_rs2_data)
  );

  branch_unit #(
    .XLEN (XLEN)
  ) branch_i (
    .i_issue     (issue),
    .i_pc        (o_es_pc),
    .i_rs1_data  (o_es_rs1_data),
    .i_rs2_data  (o_es_rs2_data),
    .i_imm       (o_es_imm),
    .i_br_en     (br_en),
    .i_jump      (jump),
    .i_jalr      (jalr),
    .i_br_func   (br_func),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

`default_nettype wire

// File: source/id_stage_ctrl.sv
// id_stage_ctrl holds the decode stage register and valid bit and derives the RAW stall and allowin
`timescale 1ns/1ns
`default_nettype none

module id_stage_ctrl #(
  parameter int XLEN = 64
) (
  input  wire                           i_clk,
  input  wire                           i_rst,
  input  wire                           i_fs_valid,
  input  wire [id_pkg::INST_WD-1:0]     i_fs_inst,
  input  wire [XLEN-1:0]                i_fs_pc,
  input  wire                           i_es_allowin,
  input  wire [id_pkg::GPR_ADDR_WD-1:0] i_es_gpr_rd,
  input  wire [id_pkg::GPR_ADDR_WD-1:0] i_ms_gpr_rd,
  input  wire [id_pkg::GPR_ADDR_WD-1:0] i_ws_gpr_rd,
  output id_pkg::inst_u                 o_inst,
  output logic [XLEN-1:0]               o_pc,
  output logic                          o_issue,
  output logic                          o_ds_allowin,
  output logic                          o_ds_to_es_valid
);
  import id_pkg::*;

  logic                   ds_valid;
  logic [GPR_ADDR_WD-1:0] rs1;
  logic [GPR_ADDR_WD-1:0] rs2;
  logic                   es_hit;
  logic                   ms_hit;
  logic                   ws_hit;
  logic                   stall;

  // both source fields compared whatever the format
  assign rs1 = o_inst.r.rs1;
  assign rs2 = o_inst.r.rs2;

  assign es_hit = (i_es_gpr_rd != '0) && (i_es_gpr_rd == rs1 || i_es_gpr_rd == rs2);
  assign ms_hit = (i_ms_gpr_rd != '0) && (i_ms_gpr_rd == rs1 || i_ms_gpr_rd == rs2);
  assign ws_hit = (i_ws_gpr_rd != '0) && (i_ws_gpr_rd == rs1 || i_ws_gpr_rd == rs2);
  assign stall  = es_hit || ms_hit || ws_hit;

  assign o_issue          = ds_valid && !stall;
  assign o_ds_to_es_valid = o_issue;
  assign o_ds_allowin     = !ds_valid || (!stall && i_es_allowin);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;  // empties when fetch has nothing
    end
  end

  // stage register loads only on a fetch transfer
  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

  // a stalled instruction stays held until its operands are free
  a_stall_holds : assert property (
    @(posedge i_clk) disable iff (i_rst)
    (ds_valid && stall) |=> ds_valid && $stable(o_inst) && $stable(o_pc)
  ) else $error("decode lost or replaced a stalled instruction");

endmodule

`default_nettype wire

// File: source/inst_decoder.sv
// inst_decoder builds immediates, ALU and memory control fields and the invalid flag for RV32I/RV64I
`timescale 1ns/1ns
`default_nettype none

module inst_decoder #(
  parameter int XLEN = 64
) (
  input  wire id_pkg::inst_u             i_inst,
  output logic [XLEN-1:0]                o_imm,
  output logic [id_pkg::ALU_OP_WD-1:0]   o_alu_op,
  output logic                           o_src1_sel,
  output logic [1:0]                     o_src2_sel,
  output logic                           o_word_op,
  output logic [id_pkg::GPR_ADDR_WD-1:0] o_rd,
  output logic                           o_gpr_wen,
  output logic                           o_mem_ren,
  output logic                           o_mem_wen,
  output logic [id_pkg::MEM_OP_WD-1:0]   o_mem_op,
  output logic                           o_br_en,
  output logic                           o_jump,
  output logic                           o_jalr,
  output logic [id_pkg::BR_FUNC_WD-1:0]  o_br_func,
  output logic                           o_invalid
);
  import id_pkg::*;

  logic signed [11:0] imm_i;
  logic signed [11:0] imm_s;
  logic signed [12:0] imm_b;
  logic signed [31:0] imm_u;
  logic signed [20:0] imm_j;
  logic [ALU_OP_WD-1:0] arith_op;

  // funct3 to ALU code with alt from inst[30]
  function automatic logic [ALU_OP_WD-1:0] arith_sel(
    input logic [2:0] f3,
    input logic       alt,
    input logic       is_imm
  );
    logic [ALU_OP_WD-1:0] op;
    case (f3)
      3'b000:  op = (alt && !is_imm) ? ALU_SUB : ALU_ADD;  // no SUBI
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // immediate formats from the raw view
  assign imm_i = i_inst.raw.imm_hi;
  assign imm_s = {i_inst.raw.imm_hi[11:5], i_inst.raw.imm_lo[4:0]};
  assign imm_b = {i_inst.raw.imm_hi[11], i_inst.raw.imm_lo[0], i_inst.raw.imm_hi[10:5],
                  i_inst.raw.imm_lo[4:1], 1'b0};
  assign imm_u = {i_inst.raw.imm_hi, i_inst.raw.imm_lo[12:5], 12'b0};
  assign imm_j = {i_inst.raw.imm_hi[11], i_inst.raw.imm_lo[12:5], i_inst.raw.imm_hi[0],
                  i_inst.raw.imm_hi[10:1], 1'b0};

  assign arith_op = arith_sel(i_inst.r.funct3, i_inst.r.funct7[5],
                              i_inst.r.opcode == OPC_OP_IMM || i_inst.r.opcode == OPC_OP_IMM_32);

  assign o_mem_op  = i_inst.r.funct3;
  assign o_br_func = i_inst.r.funct3;

  always_comb begin
    o_imm      = '0;
    o_alu_op   = ALU_ADD;
    o_src1_sel = SRC1_RS1;
    o_src2_sel = SRC2_RS2;
    o_word_op  = 1'b0;
    o_gpr_wen  = 1'b0;
    o_mem_ren  = 1'b0;
    o_mem_wen  = 1'b0;
    o_br_en    = 1'b0;
    o_jump     = 1'b0;
    o_jalr     = 1'b0;
    o_invalid  = 1'b0;

    case (i_inst.r.opcode)
      OPC_LUI: begin
        o_imm      = XLEN'(imm_u);
        o_alu_op   = ALU_LUI;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm      = XLEN'(imm_u);
        o_src1_sel = SRC1_PC;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        o_imm      = (i_inst.r.opcode == OPC_JAL) ? XLEN'(imm_j) : XLEN'(imm_i);
        o_src1_sel = SRC1_PC;   // link = pc+4
        o_src2_sel = SRC2_FOUR;
        o_gpr_wen  = 1'b1;
        o_jump     = 1'b1;
        o_jalr     = (i_inst.r.opcode == OPC_JALR);
      end
      OPC_BRANCH: begin
        o_imm   = XLEN'(imm_b);
        o_br_en = 1'b1;
      end
      OPC_LOAD: begin
        o_imm      = XLEN'(imm_i);
        o_src2_sel = SRC2_IMM;  // address = rs1+imm
        o_gpr_wen  = 1'b1;
        o_mem_ren  = 1'b1;
      end
      OPC_STORE: begin
        o_imm      = XLEN'(imm_s);
        o_src2_sel = SRC2_IMM;
        o_mem_wen  = 1'b1;
      end
      OPC_OP_IMM: begin
        o_imm      = XLEN'(imm_i);
        o_alu_op   = arith_op;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OPC_OP: begin
        o_alu_op  = arith_op;
        o_gpr_wen = 1'b1;
      end
      OPC_OP_IMM_32, OPC_OP_32: begin
        if (XLEN == 64) begin
          o_imm      = XLEN'(imm_i);
          o_alu_op   = arith_op;
          o_src2_sel = (i_inst.r.opcode == OPC_OP_32) ? SRC2_RS2 : SRC2_IMM;
          o_word_op  = 1'b1;  // result cut to 32 and sign-extended
          o_gpr_wen  = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      default: o_invalid = 1'b1;
    endcase

    // stores and branches carry imm bits in rd
    o_rd = o_gpr_wen ? i_inst.r.rd : '0;

    // every immediate format takes its sign from inst[31]
    if (o_imm != '0) begin
      a_imm_sign : assert (o_imm[XLEN-1] == i_inst.r.funct7[6])
        else $error("immediate sign does not follow inst[31]");
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+tb
source/id_pkg.sv
source/gpr_file.sv
source/branch_unit.sv
source/inst_decoder.sv
source/id_stage_ctrl.sv
source/id_stage.sv
tb/tb_id_stage.sv

// File: tb/id_stage_tests.svh
// decode stage directed tests and RISC-V instruction encoders for the testbench
`ifndef ID_STAGE_TESTS_SVH
`define ID_STAGE_TESTS_SVH

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

// imm[0] is implied zero
function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

task automatic check_reset_state();
  check("o_ds_allowin", 64'(o_ds_allowin), 64'd1);
  check("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd0);
  check("o_br_taken", 64'(o_br_taken), 64'd0);
endtask

task automatic decode_operands();
  logic [31:0] r;
  for (int i = 1; i < 32; i++) begin
    write_gpr(5'(i), {rand_word(), rand_word()});
  end
  send_inst(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP), 64'h1000);
  check("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd1);
  check("o_es_rs1_data", o_es_rs1_data, gpr_model[1]);
  check("o_es_rs2_data", o_es_rs2_data, gpr_model[2]);
  check("o_es_rd", 64'(o_es_rd), 64'd3);
  check("o_es_alu_op", 64'(o_es_alu_op), 64'(ALU_ADD));
  check("o_es_src1_sel", 64'(o_es_src1_sel), 64'(SRC1_RS1));
  check("o_es_src2_sel", 64'(o_es_src2_sel), 64'(SRC2_RS2));
  check("o_es_gpr_wen", 64'(o_es_gpr_wen), 64'd1);
  check("o_es_word_op", 64'(o_es_word_op), 64'd0);
  check("o_es_pc", o_es_pc, 64'h1000);
  r = rand_word();
  send_inst(r_type(7'h20, r[9:5], r[4:0], 3'b000, r[14:10], OPC_OP), 64'h1004);
  check("o_es_rs1_data sub", o_es_rs1_data, gpr_model[r[4:0]]);
  check("o_es_rs2_data sub", o_es_rs2_data, gpr_model[r[9:5]]);
  check("o_es_alu_op sub", 64'(o_es_alu_op), 64'(ALU_SUB));
  check("o_es_rd sub", 64'(o_es_rd), 64'(r[14:10]));
  write_gpr(5'd0, 64'hdead_beef_0bad_f00d);
  send_inst(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd4, OPC_OP), 64'h1008);
  check("o_es_rs1_data x0", o_es_rs1_data, 64'd0);
  check("o_es_rs2_data x0", o_es_rs2_data, 64'd0);
endtask

task automatic decode_immediates();
  logic [31:0] r;
  logic [12:0] imm13;
  logic [20:0] imm21;
  r = rand_word();
  send_inst(i_type(r[11:0], r[16:12], 3'b000, r[21:17], OPC_OP_IMM), 64'h2000);
  check("o_es_imm addi", o_es_imm, {{52{r[11]}}, r[11:0]});
  check("o_es_src2_sel addi", 64'(o_es_src2_sel), 64'(SRC2_IMM));
  r = rand_word();
  send_inst(s_type(r[11:0], r[16:12], r[21:17], {1'b0, r[23:22]}), 64'h2004);
  check("o_es_imm store", o_es_imm, {{52{r[11]}}, r[11:0]});
  check("o_es_mem_wen", 64'(o_es_mem_wen), 64'd1);
  check("o_es_mem_op", 64'(o_es_mem_op), 64'(r[23:22]));
  check("o_es_gpr_wen store", 64'(o_es_gpr_wen), 64'd0);
  r = rand_word();
  imm13 = {r[11:0], 1'b0};
  send_inst(b_type(imm13, r[16:12], r[21:17], 3'b001), 64'h2008);
  check("o_es_imm branch", o_es_imm, {{51{imm13[12]}}, imm13});
  r = rand_word();
  send_inst(u_type(r[19:0], r[24:20], OPC_LUI), 64'h200c);
  check("o_es_imm lui", o_es_imm, {{32{r[19]}}, r[19:0], 12'h000});
  check("o_es_alu_op lui", 64'(o_es_alu_op), 64'(ALU_LUI));
  r = rand_word();
  imm21 = {r[19:0], 1'b0};
  send_inst(j_type(imm21, r[24:20]), 64'h2010);
  check("o_es_imm jal", o_es_imm, {{43{imm21[20]}}, imm21});
  r = rand_word();
  send_inst({r[24:0], 7'b1111111}, 64'h2014);  // no such major opcode
  check("o_es_invalid", 64'(o_es_invalid), 64'd1);
  check("o_es_gpr_wen invalid", 64'(o_es_gpr_wen), 64'd0);
  check("o_es_mem_ren invalid", 64'(o_es_mem_ren), 64'd0);
  check("o_es_mem_wen invalid", 64'(o_es_mem_wen), 64'd0);
  r = rand_word();
  send_inst(i_type(r[11:0], r[16:12], 3'b000, r[21:17], OPC_OP_IMM_32), 64'h2018);
  check("o_es_imm addiw", o_es_imm, {{52{r[11]}}, r[11:0]});
  check("o_es_word_op addiw", 64'(o_es_word_op), 64'd1);
  check("o_es_invalid addiw", 64'(o_es_invalid), 64'd0);
endtask

task automatic stall_on_hazard();
  next_cycle();
  i_ms_gpr_rd = 5'd7;
  settle();
  // rs1 is x0 and es rd is zero, so only the ms match can stall
  send_inst(r_type(7'h00, 5'd7, 5'd0, 3'b000, 5'd5, OPC_OP), 64'h3000);
  repeat (3) begin
    check("o_ds_to_es_valid stalled", 64'(o_ds_to_es_valid), 64'd0);
    check("o_ds_allowin stalled", 64'(o_ds_allowin), 64'd0);
    idle(1);
  end
  next_cycle();
  i_ms_gpr_rd = 5'd9;  // in flight but unrelated
  settle();
  wait_issue();
  check("o_ds_allowin released", 64'(o_ds_allowin), 64'd1);
  check("o_es_rd", 64'(o_es_rd), 64'd5);
  next_cycle();
  i_ms_gpr_rd = 5'd0;
  settle();
  check("o_ds_to_es_valid drained", 64'(o_ds_to_es_valid), 64'd0);
endtask

task automatic hold_under_backpressure();
  logic [31:0] ra;
  logic [31:0] rb;
  ra = rand_word();
  rb = rand_word();
  next_cycle();
  i_es_allowin = 1'b0;
  settle();
  send_inst(i_type(ra[11:0], 5'd1, 3'b000, 5'd6, OPC_OP_IMM), 64'h5000);
  next_cycle();
  i_fs_valid = 1'b1;
  i_fs_inst  = i_type(rb[11:0], 5'd2, 3'b000, 5'd8, OPC_OP_IMM);
  i_fs_pc    = 64'h5004;
  settle();
  repeat (3) begin
    check("o_ds_to_es_valid held", 64'(o_ds_to_es_valid), 64'd1);
    check("o_ds_allowin held", 64'(o_ds_allowin), 64'd0);
    check("o_es_pc held", o_es_pc, 64'h5000);
    check("o_es_imm held", o_es_imm, {{52{ra[11]}}, ra[11:0]});
    check("o_es_rd held", 64'(o_es_rd), 64'd6);
    check("o_es_rs1_data held", o_es_rs1_data, gpr_model[1]);
    idle(1);
  end
  next_cycle();
  i_es_allowin = 1'b1;
  settle();
  check("o_es_pc before accept", o_es_pc, 64'h5000);
  next_cycle();
  i_fs_valid = 1'b0;
  settle();
  check("o_es_pc next", o_es_pc, 64'h5004);
  check("o_es_imm next", o_es_imm, {{52{rb[11]}}, rb[11:0]});
  check("o_es_rd next", 64'(o_es_rd), 64'd8);
endtask

task automatic branch_case(input logic [2:0] f3, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic taken);
  logic [31:0]     r;
  logic [12:0]     imm;
  logic [XLEN-1:0] pc;
  r   = rand_word();
  imm = {r[11:0], 1'b0};
  pc  = 64'h8000_0000 + 64'({r[27:16], 2'b00});
  write_gpr(5'd10, a);
  write_gpr(5'd11, b);
  send_inst(b_type(imm, 5'd11, 5'd10, f3), pc);
  check("o_ds_to_es_valid branch", 64'(o_ds_to_es_valid), 64'd1);
  check("o_br_taken", 64'(o_br_taken), 64'(taken));
  check("o_br_target", o_br_target, pc + {{51{imm[12]}}, imm});
endtask

task automatic resolve_branches();
  logic [31:0]     r;
  logic [20:0]     imm21;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] target;
  branch_case(3'b000, 64'd5, 64'd5, 1'b1);
  branch_case(3'b000, 64'd5, 64'd6, 1'b0);
  branch_case(3'b000, {XLEN{1'b1}}, 64'd1, 1'b0);
  branch_case(3'b110, 64'd1, {XLEN{1'b1}}, 1'b1);  // signed would say greater
  branch_case(3'b110, {XLEN{1'b1}}, 64'd1, 1'b0);
  branch_case(3'b110, 64'd7, 64'd7, 1'b0);
  r = rand_word();
  imm21 = {r[19:0], 1'b0};
  send_inst(j_type(imm21, 5'd1), 64'h9000);
  check("o_br_taken jal", 64'(o_br_taken), 64'd1);
  check("o_br_target jal", o_br_target, 64'h9000 + {{43{imm21[20]}}, imm21});
  r    = rand_word();
  base = {rand_word(), rand_word()};
  write_gpr(5'd12, base);
  send_inst(i_type(r[11:0], 5'd12, 3'b000, 5'd1, OPC_JALR), 64'h9100);
  target    = base + {{52{r[11]}}, r[11:0]};
  target[0] = 1'b0;
  check("o_br_taken jalr", 64'(o_br_taken), 64'd1);
  check("o_br_target jalr", o_br_target, target);
  send_inst(r_type(7'h00, 5'd11, 5'd10, 3'b000, 5'd13, OPC_OP), 64'h9200);
  check("o_ds_to_es_valid add", 64'(o_ds_to_es_valid), 64'd1);
  check("o_br_taken add", 64'(o_br_taken), 64'd0);
endtask

`endif

// File: tb/tb_id_stage.sv
// tb_id_stage: directed testbench for the RV64 instruction decode stage
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;
  import id_pkg::*;

  localparam int XLEN       = 64;
  localparam int WAIT_LIMIT = 40;  // cycles

  logic                   i_clk;
  logic                   i_rst;
  logic                   i_fs_valid;
  logic [INST_WD-1:0]     i_fs_inst;
  logic [XLEN-1:0]        i_fs_pc;
  logic                   i_es_allowin;
  logic [GPR_ADDR_WD-1:0] i_es_gpr_rd;
  logic [GPR_ADDR_WD-1:0] i_ms_gpr_rd;
  logic [GPR_ADDR_WD-1:0] i_ws_gpr_rd;
  logic                   i_ws_gpr_wen;
  logic [GPR_ADDR_WD-1:0] i_ws_gpr_waddr;
  logic [XLEN-1:0]        i_ws_gpr_wdata;
  logic                   o_ds_allowin;
  logic                   o_ds_to_es_valid;
  logic [XLEN-1:0]        o_es_pc;
  logic [XLEN-1:0]        o_es_rs1_data;
  logic [XLEN-1:0]        o_es_rs2_data;
  logic [XLEN-1:0]        o_es_imm;
  logic [ALU_OP_WD-1:0]   o_es_alu_op;
  logic                   o_es_src1_sel;
  logic [1:0]             o_es_src2_sel;
  logic                   o_es_word_op;
  logic [GPR_ADDR_WD-1:0] o_es_rd;
  logic                   o_es_gpr_wen;
  logic                   o_es_mem_ren;
  logic                   o_es_mem_wen;
  logic [MEM_OP_WD-1:0]   o_es_mem_op;
  logic                   o_es_invalid;
  logic                   o_br_taken;
  logic [XLEN-1:0]        o_br_target;

  integer          seed = 80780;
  logic [XLEN-1:0] gpr_model [32];  // expected register contents

  id_stage #(.XLEN(XLEN)) id_stage_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped on timeout");
  endtask

  // drive point 1 ns after the edge, sample point 5 ns after
  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic settle();
    #4;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      next_cycle();
      settle();
    end
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic write_gpr(input logic [4:0] addr, input logic [XLEN-1:0] data);
    next_cycle();
    i_ws_gpr_wen   = 1'b1;
    i_ws_gpr_waddr = addr;
    i_ws_gpr_wdata = data;
    next_cycle();
    i_ws_gpr_wen = 1'b0;
    settle();
    if (addr != 5'd0) begin
      gpr_model[addr] = data;  // x0 stays zero
    end
  endtask

  // present on the fetch port until accepted, returns at the sample point after it
  task automatic send_inst(input logic [31:0] inst, input logic [XLEN-1:0] pc);
    int n;
    next_cycle();
    i_fs_valid = 1'b1;
    i_fs_inst  = inst;
    i_fs_pc    = pc;
    settle();
    n = 0;
    while (o_ds_allowin !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        fail_timeout("decode to accept an instruction");
      end
      idle(1);
      n++;
    end
    next_cycle();  // accept edge
    i_fs_valid = 1'b0;
    settle();
  endtask

  task automatic wait_issue();
    int n;
    n = 0;
    while (o_ds_to_es_valid !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        fail_timeout("the held instruction to issue");
      end
      idle(1);
      n++;
    end
  endtask

  `include "id_stage_tests.svh"

  initial begin
    i_rst          = 1'b1;
    i_fs_valid     = 1'b0;
    i_fs_inst      = '0;
    i_fs_pc        = '0;
    i_es_allowin   = 1'b1;
    i_es_gpr_rd    = '0;
    i_ms_gpr_rd    = '0;
    i_ws_gpr_rd    = '0;
    i_ws_gpr_wen   = 1'b0;
    i_ws_gpr_waddr = '0;
    i_ws_gpr_wdata = '0;
    gpr_model[0]   = '0;
    repeat (16) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    settle();
    check_reset_state();
    decode_operands();
    decode_immediates();
    stall_on_hazard();
    hold_under_backpressure();
    resolve_branches();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
